// ==== Bender.yml ====
package:
  name: mac_mem

sources:
  - common/mac_mem_pkg.sv
  - common/dl_word_if.sv
  - rtl/reset_seq.sv
  - rtl/download/dl_capture.sv
  - rtl/download/floppy_status.sv
  - rtl/mem_port.sv
  - rtl/mac_mem_top.sv
  - target: test
    files:
      - dv/mac_mem_checker.sv
      - dv/tb_mac_mem.sv

// ==== common/dl_word_if.sv ====
// one captured download word, handed from capture to the memory port
// no handshake, write is a level that stays up until the slot took it
`timescale 1ns/1ns
`default_nettype none

interface dl_word_if;
	import mac_mem_pkg::*;

	// a download is in progress
	logic     active;
	// word address, image index in the top two bits
	dl_addr_t addr;
	// byte-swapped host word
	word_t    data;
	// pending write level
	logic     write;

	// capture side
	modport src (
		output active,
		output addr,
		output data,
		output write
	);

	// memory port side
	modport dst (
		input active,
		input addr,
		input data,
		input write
	);

endinterface

`default_nettype wire

// ==== common/mac_mem_pkg.sv ====
// shared widths, types and constants for the memory glue
// all sdram addresses count 16-bit words, host loader addresses count bytes
// image sizes assume the classic 400k/800k raw floppy layouts only
`default_nettype none

package mac_mem_pkg;

	// ============================================================
	// widths
	// ============================================================

	// sdram data path
	localparam int word_w       = 16;
	// sdram word address, 32M words reachable
	localparam int sdram_addr_w = 25;
	// chipset byte address, bit 0 picks the byte lane
	localparam int chip_addr_w  = 22;
	// download word address: image index on top, offset below
	localparam int dl_addr_w    = 21;
	localparam int dl_offset_w  = 19;
	// loader file index as sent by the host
	localparam int dl_index_w   = 8;

	// ============================================================
	// types
	// ============================================================

	typedef logic [word_w-1:0]       word_t;
	typedef logic [sdram_addr_w-1:0] sdram_addr_t;
	typedef logic [chip_addr_w-1:0]  chip_addr_t;
	typedef logic [dl_addr_w-1:0]    dl_addr_t;
	typedef logic [dl_index_w-1:0]   dl_index_t;

	// cpu choice, 0 = 68000, 1 = 68010, 2 = 68020 (3 is unused)
	typedef logic [1:0] cpu_sel_t;

	// ============================================================
	// constants
	// ============================================================

	// image lengths in words
	// 819200 bytes double sided, 409600 bytes single sided
	localparam sdram_addr_t img_words_ds = 25'd409600;
	localparam sdram_addr_t img_words_ss = 25'd204800;

	// downloads land above the os rom and ram map
	localparam logic [3:0] dl_region = 4'b0001;

	// rom select bit inside the chipset sdram word address
	// ram and rom share the lower 21 bits
	localparam int rom_region_bit_pos = 21;

	// reset hold in 8 MHz ticks, roughly 8 ms
	localparam logic [15:0] rst_hold_default = 16'd65535;

	// activity led stretch in clk_sys cycles
	localparam logic [19:0] act_hold_default = 20'd500000;

	// loader indices of the two floppy drives
	localparam dl_index_t idx_floppy_int = 8'd1;
	localparam dl_index_t idx_floppy_ext = 8'd2;

endpackage

`default_nettype wire

// ==== dv/mac_mem_checker.sv ====
// concurrent checks on the memory glue top level, attached with bind
// host wait, download byte strobes and reset propagation only
`timescale 1ns/1ns
`default_nettype none

module mac_mem_checker (
	input logic       clk_sys,
	input logic       rst_n,
	input logic       ioctl_wr,
	input logic       ioctl_wait,
	input logic       dl_active,
	input logic       dl_slot,
	input logic [1:0] mem_ds,
	input logic       sys_reset_n
);

	// failed assertions so far
	int fail_cnt = 0;

	// wait level only rises one cycle after a host write
	wait_after_wr: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(ioctl_wait) |-> $past(ioctl_wr))
		else begin
			fail_cnt++;
			$error("ioctl_wait rose without ioctl_wr in the previous cycle");
		end

	// download slot always writes whole words
	dl_full_word: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(dl_active && dl_slot) |-> (mem_ds == 2'b11))
		else begin
			fail_cnt++;
			$error("mem_ds not 11 during a download slot");
		end

	// board reset reaches the core within one cycle
	rst_to_sys: assert property (@(posedge clk_sys)
		!rst_n |=> !sys_reset_n)
		else begin
			fail_cnt++;
			$error("sys_reset_n high one cycle after rst_n low");
		end

endmodule

bind mac_mem_top mac_mem_checker u_checker (
	.clk_sys     (clk_sys),
	.rst_n       (rst_n),
	.ioctl_wr    (ioctl_wr),
	.ioctl_wait  (ioctl_wait),
	.dl_active   (dl_active),
	.dl_slot     (dl_slot),
	.mem_ds      (mem_ds),
	.sys_reset_n (sys_reset_n)
);

`default_nettype wire

// ==== dv/tb_mac_mem.sv ====
// table-driven testbench for the memory glue top level
// short reset hold and led stretch, tick_8m strobes every fourth clk_sys cycle
// inputs change 10 ns after the rising edge, outputs are read mid-cycle or there
`timescale 1ns/1ns
`default_nettype none

module tb_mac_mem;
	import mac_mem_pkg::*;

	// ============================================================
	// parameters and cycle budget
	// ============================================================

	localparam logic [15:0] hold_ticks = 16'd8;
	localparam logic [19:0] act_hold   = 20'd20;
	localparam int tick_div    = 4;
	localparam int n_dl        = 6;
	localparam int n_chip      = 8;
	localparam int n_rd        = 6;
	localparam int n_fl        = 8;
	localparam int wait_max    = 8;
	localparam int hold_cycles = (int'(hold_ticks) + 2) * tick_div;
	localparam int led_max     = int'(act_hold) + 8;
	// two reset holds plus the menu wait, then every table row with its slack
	localparam int run_cycles  = 3 * hold_cycles + n_dl * (4 + wait_max) + n_chip
		+ n_rd + 3 * n_fl + 2 * (led_max + 3) + 20;

	// ============================================================
	// dut signals
	// ============================================================

	logic        clk_sys, rst_n, tick_8m, menu_reset, cpu_reset_n, mem_4mb_req;
	cpu_sel_t    cpu_req, cpu_sel;
	logic        sys_reset_n, mem_4mb;
	logic        ioctl_wr, dl_active, dl_slot, ioctl_wait;
	sdram_addr_t ioctl_addr, mem_addr;
	word_t       ioctl_data, chip_wdata, cpu_rdata, sdram_rdata, mem_wdata;
	dl_index_t   dl_index;
	chip_addr_t  chip_addr;
	logic        uds_n, lds_n, ram_we_n, ram_oe_n, rom_oe_n, disk_ack;
	logic [1:0]  mem_ds;
	logic        mem_we, mem_oe, disk_led;
	logic [1:0]  disk_eject, disk_act, disk_motor, disk_inserted, disk_double;

	// ============================================================
	// stimulus tables
	// ============================================================

	typedef struct packed {
		logic [1:0]  idx;
		sdram_addr_t addr;
		word_t       data;
		sdram_addr_t exp_addr;
		word_t       exp_data;
	} dl_row_t;

	// strb_n holds uds, lds, ram we, ram oe, rom oe from top down
	typedef struct packed {
		chip_addr_t  addr;
		word_t       wdata;
		logic [4:0]  strb_n;
		word_t       rdata;
		sdram_addr_t exp_addr;
		logic [1:0]  exp_ds;
		logic        exp_we;
		logic        exp_oe;
	} chip_row_t;

	typedef struct packed {
		logic  act;
		logic  slot;
		logic  ack;
		logic  a0;
		word_t rdata;
		word_t exp;
	} rd_row_t;

	// drive is an eject mask on eject rows, else the loader index
	typedef struct packed {
		logic        eject;
		logic [1:0]  drive;
		sdram_addr_t len;
		logic [1:0]  exp_ins;
		logic [1:0]  exp_dbl;
	} fl_row_t;

	dl_row_t   dl_tab   [0:n_dl-1];
	chip_row_t chip_tab [0:n_chip-1];
	rd_row_t   rd_tab   [0:n_rd-1];
	fl_row_t   fl_tab   [0:n_fl-1];

	int          chk_cnt = 0;
	int          err_cnt = 0;
	logic [31:0] lcg_state = 32'd849;
	logic [1:0]  tick_cnt;

	mac_mem_top #(.hold_ticks(hold_ticks), .act_hold(act_hold)) dut (.*);

	// ============================================================
	// clock, tick strobe and watchdog
	// ============================================================

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// 8 MHz tick modelled as one cycle in four
	initial begin
		tick_8m  = 1'b0;
		tick_cnt = 2'd0;
		forever begin
			@(posedge clk_sys);
			#10;
			tick_8m  = (tick_cnt == 2'd3);
			tick_cnt = tick_cnt + 2'd1;
		end
	end

	initial begin
		repeat (2 * run_cycles) @(posedge clk_sys);
		$display("watchdog expired after %0d cycles, the test did not finish", 2 * run_cycles);
		$display("CHECKS FAILED");
		$finish;
	end

	// ============================================================
	// helpers
	// ============================================================

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// back to the drive point of the next cycle
	task automatic next_cycle();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		chk_cnt++;
		if (exp !== got) begin
			err_cnt++;
			$display("ERR %s exp=%h got=%h", name, exp, got);
		end
	endtask

	task automatic report_failure(input string msg);
		err_cnt++;
		$display("%s", msg);
	endtask

	task automatic build_tables();
		logic [31:0]         r;
		logic [3:0]          ctl;
		logic [4*n_rd-1:0]   ctl_list = {4'b1100, 4'b1111, 4'b0010, 4'b0011, 4'b1011, 4'b0100};
		for (int i = 0; i < n_dl; i++) begin
			r = lcg_next();
			dl_tab[i].idx  = i[1:0];
			dl_tab[i].addr = r[24:0];
			r = lcg_next();
			dl_tab[i].data = r[15:0];
			// download region, image index, then the word offset of the byte address
			dl_tab[i].exp_addr = {4'b0001, i[1:0], dl_tab[i].addr[19:1]};
			dl_tab[i].exp_data = {r[7:0], r[15:8]};
		end
		for (int i = 0; i < n_chip; i++) begin
			r = lcg_next();
			chip_tab[i].addr   = r[21:0];
			chip_tab[i].strb_n = r[26:22];
			r = lcg_next();
			chip_tab[i].wdata  = r[15:0];
			chip_tab[i].rdata  = r[31:16];
			// rom bit from rom_oe_n above the word offset
			chip_tab[i].exp_addr = {3'b000, ~chip_tab[i].strb_n[0], chip_tab[i].addr[21:1]};
			chip_tab[i].exp_ds   = ~chip_tab[i].strb_n[4:3];
			chip_tab[i].exp_we   = ~chip_tab[i].strb_n[2];
			chip_tab[i].exp_oe   = ~chip_tab[i].strb_n[1] | ~chip_tab[i].strb_n[0];
		end
		for (int i = 0; i < n_rd; i++) begin
			r   = lcg_next();
			ctl = ctl_list[4*(n_rd-1-i) +: 4];
			rd_tab[i].act   = ctl[3];
			rd_tab[i].slot  = ctl[2];
			rd_tab[i].ack   = ctl[1];
			rd_tab[i].a0    = ctl[0];
			rd_tab[i].rdata = r[15:0];
			if (ctl[3] && ctl[2]) begin
				rd_tab[i].exp = 16'hffff;
			end else if (ctl[1]) begin
				rd_tab[i].exp = ctl[0] ? {r[7:0], r[7:0]} : {r[15:8], r[15:8]};
			end else begin
				rd_tab[i].exp = r[15:0];
			end
		end
		// 819200 bytes double sided, 409600 bytes single sided
		fl_tab[0] = {1'b1, 2'b11, 25'd0,      2'b00, 2'b00};
		fl_tab[1] = {1'b0, 2'd1,  25'd819200, 2'b01, 2'b01};
		fl_tab[2] = {1'b0, 2'd2,  25'd409600, 2'b11, 2'b01};
		fl_tab[3] = {1'b0, 2'd1,  25'd123456, 2'b10, 2'b00};
		fl_tab[4] = {1'b0, 2'd1,  25'd409600, 2'b11, 2'b00};
		fl_tab[5] = {1'b1, 2'b10, 25'd0,      2'b01, 2'b00};
		fl_tab[6] = {1'b0, 2'd2,  25'd819200, 2'b11, 2'b10};
		fl_tab[7] = {1'b1, 2'b01, 25'd0,      2'b10, 2'b10};
	endtask

	// counts tick strobes until sys_reset_n is released
	task automatic count_hold_ticks(output int ticks);
		int cyc;
		ticks = 0;
		cyc   = 0;
		while (sys_reset_n !== 1'b1 && cyc < hold_cycles) begin
			@(posedge clk_sys);
			if (tick_8m) begin
				ticks++;
			end
			#1;
			cyc++;
		end
		if (sys_reset_n !== 1'b1) begin
			report_failure("sys_reset_n was never released after the reset hold");
		end
		#9;
	endtask

	// ============================================================
	// test sections
	// ============================================================

	task automatic run_reset_test();
		int ticks;
		bit seen;
		count_hold_ticks(ticks);
		check_value("sys_reset_n ticks", int'(hold_ticks) + 1, ticks);
		check_value("mem_4mb", 1, mem_4mb);
		check_value("cpu_sel", 2, cpu_sel);
		// menu reset with a new configuration
		mem_4mb_req = 1'b0;
		cpu_req     = 2'd1;
		menu_reset  = 1'b1;
		seen        = 1'b0;
		while (!seen) begin
			@(posedge clk_sys);
			seen = tick_8m;
			#10;
		end
		menu_reset = 1'b0;
		check_value("sys_reset_n", 0, sys_reset_n);
		count_hold_ticks(ticks);
		check_value("sys_reset_n ticks", int'(hold_ticks) + 1, ticks);
		check_value("mem_4mb", 0, mem_4mb);
		check_value("cpu_sel", 1, cpu_sel);
		// the latch keeps its value once the hold is over
		mem_4mb_req = 1'b1;
		cpu_req     = 2'd2;
		repeat (2 * tick_div) begin
			next_cycle();
		end
		check_value("mem_4mb", 0, mem_4mb);
		check_value("cpu_sel", 1, cpu_sel);
	endtask

	task automatic run_download_test();
		int n;
		dl_active = 1'b1;
		for (int i = 0; i < n_dl; i++) begin
			dl_index   = {6'd0, dl_tab[i].idx};
			ioctl_addr = dl_tab[i].addr;
			ioctl_data = dl_tab[i].data;
			ioctl_wr   = 1'b1;
			next_cycle();
			ioctl_wr = 1'b0;
			check_value("ioctl_wait", 1, ioctl_wait);
			next_cycle();
			dl_slot = 1'b1;
			#40;
			check_value("mem_addr", dl_tab[i].exp_addr, mem_addr);
			check_value("mem_wdata", dl_tab[i].exp_data, mem_wdata);
			check_value("mem_ds", 3, mem_ds);
			check_value("mem_we", 1, mem_we);
			next_cycle();
			dl_slot = 1'b0;
			n = 0;
			while (ioctl_wait && n < wait_max) begin
				next_cycle();
				n++;
			end
			if (ioctl_wait) begin
				report_failure("ioctl_wait stayed high after the download slot closed");
			end
			next_cycle();
		end
		// index 0 keeps the floppy state untouched
		dl_index  = 8'd0;
		dl_active = 1'b0;
		next_cycle();
	endtask

	task automatic run_chip_test();
		for (int i = 0; i < n_chip; i++) begin
			chip_addr   = chip_tab[i].addr;
			chip_wdata  = chip_tab[i].wdata;
			sdram_rdata = chip_tab[i].rdata;
			{uds_n, lds_n, ram_we_n, ram_oe_n, rom_oe_n} = chip_tab[i].strb_n;
			#40;
			check_value("mem_addr", chip_tab[i].exp_addr, mem_addr);
			check_value("mem_wdata", chip_tab[i].wdata, mem_wdata);
			check_value("mem_ds", chip_tab[i].exp_ds, mem_ds);
			check_value("mem_we", chip_tab[i].exp_we, mem_we);
			check_value("mem_oe", chip_tab[i].exp_oe, mem_oe);
			check_value("cpu_rdata", chip_tab[i].rdata, cpu_rdata);
			next_cycle();
		end
		{uds_n, lds_n, ram_we_n, ram_oe_n, rom_oe_n} = 5'b11111;
	endtask

	task automatic run_read_test();
		for (int i = 0; i < n_rd; i++) begin
			dl_active   = rd_tab[i].act;
			dl_slot     = rd_tab[i].slot;
			disk_ack    = rd_tab[i].ack;
			chip_addr   = {21'd0, rd_tab[i].a0};
			sdram_rdata = rd_tab[i].rdata;
			#40;
			check_value("cpu_rdata", rd_tab[i].exp, cpu_rdata);
			next_cycle();
		end
		dl_active = 1'b0;
		dl_slot   = 1'b0;
		disk_ack  = 1'b0;
		next_cycle();
	endtask

	task automatic run_floppy_test();
		for (int i = 0; i < n_fl; i++) begin
			if (fl_tab[i].eject) begin
				disk_eject = fl_tab[i].drive;
				next_cycle();
				disk_eject = 2'b00;
			end else begin
				dl_index   = {6'd0, fl_tab[i].drive};
				ioctl_addr = fl_tab[i].len;
				dl_active  = 1'b1;
				next_cycle();
				dl_active = 1'b0;
				next_cycle();
				dl_index = 8'd0;
			end
			check_value("disk_inserted", fl_tab[i].exp_ins, disk_inserted);
			check_value("disk_double", fl_tab[i].exp_dbl, disk_double);
		end
	endtask

	task automatic run_led_test();
		int   len;
		logic idle;
		for (int m = 0; m < 2; m++) begin
			// a running motor lights the led, activity flips it
			idle       = m[0];
			disk_motor = {1'b0, m[0]};
			next_cycle();
			next_cycle();
			check_value("disk_led", idle, disk_led);
			disk_act = m[0] ? 2'b10 : 2'b01;
			next_cycle();
			disk_act = 2'b00;
			len = 0;
			next_cycle();
			while (disk_led !== idle && len < led_max) begin
				len++;
				next_cycle();
			end
			check_value("disk_led stretch", act_hold, len);
		end
		disk_motor = 2'b00;
	endtask

	// ============================================================
	// main sequence
	// ============================================================

	initial begin
		rst_n       = 1'b0;
		menu_reset  = 1'b0;
		cpu_reset_n = 1'b1;
		mem_4mb_req = 1'b1;
		cpu_req     = 2'd2;
		ioctl_wr    = 1'b0;
		ioctl_addr  = '0;
		ioctl_data  = '0;
		dl_index    = '0;
		dl_active   = 1'b0;
		dl_slot     = 1'b0;
		chip_addr   = '0;
		chip_wdata  = '0;
		{uds_n, lds_n, ram_we_n, ram_oe_n, rom_oe_n} = 5'b11111;
		disk_ack    = 1'b0;
		sdram_rdata = '0;
		disk_eject  = 2'b00;
		disk_act    = 2'b00;
		disk_motor  = 2'b00;
		build_tables();
		repeat (4) @(posedge clk_sys);
		#10;
		rst_n = 1'b1;
		run_reset_test();
		run_download_test();
		run_chip_test();
		run_read_test();
		run_floppy_test();
		run_led_test();
		// failed bound assertions count as errors too
		err_cnt = err_cnt + dut.u_checker.fail_cnt;
		$display("%0d checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/mac_mem_pkg.sv
common/dl_word_if.sv
rtl/reset_seq.sv
rtl/download/dl_capture.sv
rtl/download/floppy_status.sv
rtl/mem_port.sv
rtl/mac_mem_top.sv
dv/mac_mem_checker.sv
dv/tb_mac_mem.sv

// ==== rtl/download/dl_capture.sv ====
// captures host loader words and turns them into sdram writes for the download slot
// the host must not pulse ioctl_wr while ioctl_wait is high
// only the low two bits of dl_index reach the word address
`timescale 1ns/1ns
`default_nettype none

module dl_capture (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic                     ioctl_wr,
	input  mac_mem_pkg::sdram_addr_t ioctl_addr,
	input  mac_mem_pkg::word_t       ioctl_data,
	input  mac_mem_pkg::dl_index_t   dl_index,
	input  logic                     dl_active,
	input  logic                     dl_slot,
	output logic                     ioctl_wait,
	dl_word_if.src                   dl
);
	import mac_mem_pkg::*;

	// number of image index bits kept on top of the word offset
	localparam int idx_bits = dl_addr_w - dl_offset_w;

	// captured word and its address
	dl_addr_t addr_q;
	word_t    data_q;
	// pending write level seen by the memory port
	logic     write_q;
	// dl_slot one cycle back, for the closing edge
	logic     slot_q;
	// falling edge of dl_slot
	logic     slot_fall;

	assign slot_fall = slot_q & ~dl_slot;

	// ============================================================
	// word capture
	// ============================================================

	// host sends little-endian pairs, the 68k wants big-endian
	// byte address to word offset drops bit 0
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr) begin
			data_q <= {ioctl_data[7:0], ioctl_data[15:8]};
			addr_q <= {dl_index[idx_bits-1:0], ioctl_addr[dl_offset_w:1]};
		end
	end

	// ============================================================
	// slot timing and host wait
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ioctl_wait <= 1'b0;
			write_q    <= 1'b0;
			slot_q     <= 1'b0;
		end else begin
			// stall the host as soon as a word arrives
			if (ioctl_wr) begin
				ioctl_wait <= 1'b1;
			end

			slot_q <= dl_slot;

			// write level only moves outside the slot so it is stable during it
			if (!dl_slot) begin
				write_q <= ioctl_wait;
			end

			// a slot with a pending write just closed, word is in memory
			if (slot_fall && write_q) begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	// hand over to the memory port
	assign dl.active = dl_active;
	assign dl.addr   = addr_q;
	assign dl.data   = data_q;
	assign dl.write  = write_q;

endmodule

`default_nettype wire

// ==== rtl/download/floppy_status.sv ====
// floppy image side detection and disk activity led
// image type is judged only from the final length of a download
// index 1 is the internal drive, index 2 the external one
`timescale 1ns/1ns
`default_nettype none

module floppy_status #(
	parameter logic [19:0] act_hold = mac_mem_pkg::act_hold_default
) (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic                     dl_active,
	input  mac_mem_pkg::dl_index_t   dl_index,
	input  mac_mem_pkg::sdram_addr_t ioctl_addr,
	input  logic [1:0]               disk_eject,
	input  logic [1:0]               disk_act,
	input  logic [1:0]               disk_motor,
	output logic [1:0]               disk_inserted,
	output logic [1:0]               disk_double,
	output logic                     disk_led
);
	import mac_mem_pkg::*;

	// per drive, double and single sided image present
	logic [1:0]  ds_q;
	logic [1:0]  ss_q;
	// dl_active one cycle back
	logic        active_q;
	// download just finished
	logic        dl_done;
	// final length in words, the byte address has one bit too many
	sdram_addr_t word_cnt;
	// activity stretch counter and its output
	logic [19:0] act_cnt;
	logic        act_q;

	assign dl_done  = active_q & ~dl_active;
	assign word_cnt = {1'b0, ioctl_addr[sdram_addr_w-1:1]};

	// ============================================================
	// image side detection
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			active_q <= 1'b0;
			ds_q     <= 2'b00;
			ss_q     <= 2'b00;
		end else begin
			active_q <= dl_active;
			for (int i = 0; i < 2; i++) begin
				if (dl_done && dl_index == (i == 0 ? idx_floppy_int : idx_floppy_ext)) begin
					ds_q[i] <= (word_cnt == img_words_ds);
					ss_q[i] <= (word_cnt == img_words_ss);
				end
				// eject from the os wins over a finishing download
				if (disk_eject[i]) begin
					ds_q[i] <= 1'b0;
					ss_q[i] <= 1'b0;
				end
			end
		end
	end

	// unknown lengths leave the drive empty
	assign disk_inserted = ds_q | ss_q;
	assign disk_double   = ds_q;

	// ============================================================
	// activity led
	// ============================================================

	// every pulse restarts the stretch
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			act_cnt <= 20'd0;
			act_q   <= 1'b0;
		end else begin
			act_q <= (act_cnt != 20'd0);
			if (|disk_act) begin
				act_cnt <= act_hold;
			end else if (act_cnt != 20'd0) begin
				act_cnt <= act_cnt - 20'd1;
			end
		end
	end

	// running motor turns the led on, activity blinks it off
	assign disk_led = dl_active | (act_q ^ |disk_motor);

endmodule

`default_nettype wire

// ==== rtl/mac_mem_top.sv ====
// memory and housekeeping glue between the core, the host loader and sdram
// download capture feeds the memory port, reset and floppy status run beside
`timescale 1ns/1ns
`default_nettype none

module mac_mem_top #(
	parameter logic [15:0] hold_ticks = mac_mem_pkg::rst_hold_default,
	parameter logic [19:0] act_hold   = mac_mem_pkg::act_hold_default
) (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	// reset sources and configuration
	input  logic                     tick_8m,
	input  logic                     menu_reset,
	input  logic                     cpu_reset_n,
	input  logic                     mem_4mb_req,
	input  mac_mem_pkg::cpu_sel_t    cpu_req,
	output logic                     sys_reset_n,
	output logic                     mem_4mb,
	output mac_mem_pkg::cpu_sel_t    cpu_sel,
	// host loader
	input  logic                     ioctl_wr,
	input  mac_mem_pkg::sdram_addr_t ioctl_addr,
	input  mac_mem_pkg::word_t       ioctl_data,
	input  mac_mem_pkg::dl_index_t   dl_index,
	input  logic                     dl_active,
	input  logic                     dl_slot,
	output logic                     ioctl_wait,
	// chipset request
	input  mac_mem_pkg::chip_addr_t  chip_addr,
	input  mac_mem_pkg::word_t       chip_wdata,
	input  logic                     uds_n,
	input  logic                     lds_n,
	input  logic                     ram_we_n,
	input  logic                     ram_oe_n,
	input  logic                     rom_oe_n,
	input  logic                     disk_ack,
	output mac_mem_pkg::word_t       cpu_rdata,
	// sdram request
	input  mac_mem_pkg::word_t       sdram_rdata,
	output mac_mem_pkg::sdram_addr_t mem_addr,
	output mac_mem_pkg::word_t       mem_wdata,
	output logic [1:0]               mem_ds,
	output logic                     mem_we,
	output logic                     mem_oe,
	// floppy drives
	input  logic [1:0]               disk_eject,
	input  logic [1:0]               disk_act,
	input  logic [1:0]               disk_motor,
	output logic [1:0]               disk_inserted,
	output logic [1:0]               disk_double,
	output logic                     disk_led
);

	// captured download word
	dl_word_if dl_bus ();

	reset_seq #(.hold_ticks(hold_ticks)) u_reset_seq (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.tick_8m     (tick_8m),
		.menu_reset  (menu_reset),
		.cpu_reset_n (cpu_reset_n),
		.mem_4mb_req (mem_4mb_req),
		.cpu_req     (cpu_req),
		.sys_reset_n (sys_reset_n),
		.mem_4mb     (mem_4mb),
		.cpu_sel     (cpu_sel)
	);

	dl_capture u_dl_capture (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.ioctl_wr   (ioctl_wr),
		.ioctl_addr (ioctl_addr),
		.ioctl_data (ioctl_data),
		.dl_index   (dl_index),
		.dl_active  (dl_active),
		.dl_slot    (dl_slot),
		.ioctl_wait (ioctl_wait),
		.dl         (dl_bus.src)
	);

	mem_port u_mem_port (
		.dl          (dl_bus.dst),
		.dl_slot     (dl_slot),
		.chip_addr   (chip_addr),
		.chip_wdata  (chip_wdata),
		.uds_n       (uds_n),
		.lds_n       (lds_n),
		.ram_we_n    (ram_we_n),
		.ram_oe_n    (ram_oe_n),
		.rom_oe_n    (rom_oe_n),
		.disk_ack    (disk_ack),
		.sdram_rdata (sdram_rdata),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_ds      (mem_ds),
		.mem_we      (mem_we),
		.mem_oe      (mem_oe),
		.cpu_rdata   (cpu_rdata)
	);

	// side detection reads the final loader address directly
	floppy_status #(.act_hold(act_hold)) u_floppy_status (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.dl_active     (dl_active),
		.dl_index      (dl_index),
		.ioctl_addr    (ioctl_addr),
		.disk_eject    (disk_eject),
		.disk_act      (disk_act),
		.disk_motor    (disk_motor),
		.disk_inserted (disk_inserted),
		.disk_double   (disk_double),
		.disk_led      (disk_led)
	);

endmodule

`default_nettype wire

// ==== rtl/mem_port.sv ====
// picks the sdram request source and shapes the read data for the chipset
// purely combinational, no latency
// disk image reads are assumed byte wide, chip_addr bit 0 picks the lane
`timescale 1ns/1ns
`default_nettype none

module mem_port (
	dl_word_if.dst                   dl,
	input  logic                     dl_slot,
	input  mac_mem_pkg::chip_addr_t  chip_addr,
	input  mac_mem_pkg::word_t       chip_wdata,
	input  logic                     uds_n,
	input  logic                     lds_n,
	input  logic                     ram_we_n,
	input  logic                     ram_oe_n,
	input  logic                     rom_oe_n,
	input  logic                     disk_ack,
	input  mac_mem_pkg::word_t       sdram_rdata,
	output mac_mem_pkg::sdram_addr_t mem_addr,
	output mac_mem_pkg::word_t       mem_wdata,
	output logic [1:0]               mem_ds,
	output logic                     mem_we,
	output logic                     mem_oe,
	output mac_mem_pkg::word_t       cpu_rdata
);
	import mac_mem_pkg::*;

	// download owns the bus only inside its slot
	logic        dl_cycle;
	// chipset byte address mapped to an sdram word address
	sdram_addr_t chip_map;
	// byte lane of a disk read copied into both halves
	word_t       disk_byte;

	assign dl_cycle = dl.active & dl_slot;

	// ============================================================
	// request select
	// ============================================================

	// ram and rom share the word offset, the rom bit splits them
	always_comb begin
		chip_map                           = '0;
		chip_map[rom_region_bit_pos-1:0]   = chip_addr[rom_region_bit_pos:1];
		chip_map[rom_region_bit_pos]       = ~rom_oe_n;
	end

	// downloads write whole words and never read
	assign mem_addr  = dl_cycle ? {dl_region, dl.addr} : chip_map;
	assign mem_wdata = dl_cycle ? dl.data : chip_wdata;
	assign mem_ds    = dl_cycle ? 2'b11 : {~uds_n, ~lds_n};
	assign mem_we    = dl_cycle ? dl.write : ~ram_we_n;
	assign mem_oe    = dl_cycle ? 1'b0 : (~ram_oe_n | ~rom_oe_n);

	// ============================================================
	// read data shaping
	// ============================================================

	// odd address takes the low byte, as on the 68k bus
	assign disk_byte = chip_addr[0] ? {sdram_rdata[7:0], sdram_rdata[7:0]}
	                                : {sdram_rdata[15:8], sdram_rdata[15:8]};

	// all ones keeps the screen black while a download runs
	always_comb begin
		if (dl_cycle) begin
			cpu_rdata = '1;
		end else if (disk_ack) begin
			cpu_rdata = disk_byte;
		end else begin
			cpu_rdata = sdram_rdata;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/reset_seq.sv ====
// merges the reset sources and holds the system in reset for hold_ticks 8 MHz ticks
// tick_8m is a one-cycle strobe on clk_sys, sources are only sampled on ticks
// memory size and cpu choice only change while the hold counter runs
`timescale 1ns/1ns
`default_nettype none

module reset_seq #(
	parameter logic [15:0] hold_ticks = mac_mem_pkg::rst_hold_default
) (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  tick_8m,
	input  logic                  menu_reset,
	input  logic                  cpu_reset_n,
	input  logic                  mem_4mb_req,
	input  mac_mem_pkg::cpu_sel_t cpu_req,
	output logic                  sys_reset_n,
	output logic                  mem_4mb,
	output mac_mem_pkg::cpu_sel_t cpu_sel
);

	// hold counter, counts ticks down to zero
	logic [15:0] hold_cnt;
	// any source asking for reset right now
	logic        src_active;
	// counter still running
	logic        holding;

	assign src_active = menu_reset | ~cpu_reset_n;
	assign holding    = (hold_cnt != 16'd0);

	// ============================================================
	// hold counter and release
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			// power-on behaves like a source that just went away
			hold_cnt    <= hold_ticks;
			sys_reset_n <= 1'b0;
		end else if (tick_8m) begin
			if (src_active) begin
				// restart the full hold on every active tick
				hold_cnt    <= hold_ticks;
				sys_reset_n <= 1'b0;
			end else if (holding) begin
				hold_cnt <= hold_cnt - 16'd1;
			end else begin
				// counter empty, one extra tick before release
				sys_reset_n <= 1'b1;
			end
		end
	end

	// ============================================================
	// configuration latch
	// ============================================================

	// copied only while counting down so the cpu never sees a change mid-run
	always_ff @(posedge clk_sys) begin
		if (tick_8m && !src_active && holding) begin
			mem_4mb <= mem_4mb_req;
			cpu_sel <= cpu_req;
		end
	end

endmodule

`default_nettype wire
